//--- verilog/core_cfg_pkg.sv
package core_cfg_pkg;

    localparam int WARPS_PER_CORE = 2;
    localparam int THREADS_PER_WARP = 4;
    localparam int DATA_WIDTH = 32;
    localparam int IMEM_ADDR_WIDTH = 8;
    localparam int DMEM_ADDR_WIDTH = 8;
    localparam int WARP_INDEX_WIDTH = 1;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
    typedef logic [THREADS_PER_WARP-1:0] lane_mask_t;

    // Per-warp FSM, walked once per instruction
    typedef enum logic [3:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_REQUEST,
        WARP_WAIT,
        WARP_EXECUTE,
        WARP_SYNC_WAIT,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_t;

    typedef struct packed {
        imem_addr_t base_address;
        data_t      num_warps;
    } kernel_config_t;

    typedef struct packed {
        dmem_addr_t address;
        data_t      data;
    } dmem_write_t;

endpackage

//--- verilog/gpu_isa_pkg.sv
package gpu_isa_pkg;

    import core_cfg_pkg::*;

    typedef logic [31:0] instruction_t;

    typedef enum logic [3:0] {
        NOP   = 4'h0,
        ADD   = 4'h1,
        SUB   = 4'h2,
        AND   = 4'h3,
        OR    = 4'h4,
        ADDI  = 4'h5,
        STORE = 4'h6,
        SYNC  = 4'h7,
        HALT  = 4'h8
    } opcode_t;

    // Instruction word layout
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int RD_MSB = 27;
    localparam int RD_LSB = 24;
    localparam int RS1_MSB = 23;
    localparam int RS1_LSB = 20;
    localparam int RS2_MSB = 19;
    localparam int RS2_LSB = 16;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int IMM_WIDTH = 16;

    localparam int NUM_REGS = 16;
    typedef logic [3:0] reg_addr_t;

    // Hardwired registers, writes to them are dropped
    localparam reg_addr_t REG_ZERO = 4'd0;
    localparam reg_addr_t REG_TID = 4'd1;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;
        logic      reg_write;
    } decoded_instr_t;

endpackage

//--- verilog/warp_fetcher.sv
module warp_fetcher
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  warp_state_t  warp_state,
    input  imem_addr_t   pc,
    input  logic         imem_ready,
    input  instruction_t imem_data,
    output logic         imem_valid,
    output imem_addr_t   imem_address,
    output logic         fetch_done,
    output instruction_t instruction
);

    typedef enum logic [1:0] {
        FETCHER_IDLE,
        FETCHER_REQUESTING,
        FETCHER_DONE
    } fetcher_state_t;

    fetcher_state_t state;

    assign imem_valid = (state == FETCHER_REQUESTING);
    assign fetch_done = (state == FETCHER_DONE);

    // The PC only moves in UPDATE, so it holds for the whole request
    assign imem_address = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCHER_IDLE;
        end else begin
            case (state)
                FETCHER_IDLE: begin
                    if (warp_state == WARP_FETCH) begin
                        state <= FETCHER_REQUESTING;
                    end
                end
                FETCHER_REQUESTING: begin
                    if (imem_ready) begin
                        state <= FETCHER_DONE;
                    end
                end
                FETCHER_DONE: begin
                    // Wait for the scheduler to move the warp on
                    if (warp_state != WARP_FETCH) begin
                        state <= FETCHER_IDLE;
                    end
                end
                default: state <= FETCHER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid && imem_ready) begin
            instruction <= imem_data;
        end
    end

endmodule

//--- verilog/instr_decoder.sv
module instr_decoder
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  warp_state_t    warp_state,
    input  instruction_t   instruction,
    output decoded_instr_t decoded
);

    decoded_instr_t fields;

    always_comb begin
        fields.op = opcode_t'(instruction[OPCODE_MSB:OPCODE_LSB]);
        fields.rd = instruction[RD_MSB:RD_LSB];
        fields.rs1 = instruction[RS1_MSB:RS1_LSB];
        fields.rs2 = instruction[RS2_MSB:RS2_LSB];
        fields.imm = {{(DATA_WIDTH - IMM_WIDTH){instruction[IMM_MSB]}},
                      instruction[IMM_MSB:IMM_LSB]};
        // Only ALU ops write back, STORE/SYNC/HALT/NOP leave registers alone
        case (fields.op)
            ADD, SUB, AND, OR, ADDI: fields.reg_write = 1'b1;
            default: fields.reg_write = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (warp_state == WARP_DECODE) begin
            decoded <= fields;
        end
    end

endmodule

//--- verilog/vector_reg_file.sv
module vector_reg_file
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [WARP_INDEX_WIDTH-1:0] warp_id,
    input  logic                        write_enable,
    input  reg_addr_t                   rd,
    input  reg_addr_t                   rs1,
    input  reg_addr_t                   rs2,
    input  data_t                       result [THREADS_PER_WARP],
    input  lane_mask_t                  lane_mask,
    output data_t                       rs1_data [THREADS_PER_WARP],
    output data_t                       rs2_data [THREADS_PER_WARP]
);

    logic rd_writable;

    assign rd_writable = (rd != REG_ZERO) && (rd != REG_TID);

    generate
        for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_lane
            data_t regs [NUM_REGS];
            data_t thread_index;

            // Global thread number of this lane
            assign thread_index = data_t'(warp_id) * THREADS_PER_WARP + l;

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int r = 0; r < NUM_REGS; r++) begin
                        regs[r] <= '0;
                    end
                end else if (write_enable && lane_mask[l] && rd_writable) begin
                    regs[rd] <= result[l];
                end
            end

            assign rs1_data[l] = (rs1 == REG_ZERO) ? '0 :
                                 (rs1 == REG_TID)  ? thread_index : regs[rs1];
            assign rs2_data[l] = (rs2 == REG_ZERO) ? '0 :
                                 (rs2 == REG_TID)  ? thread_index : regs[rs2];
        end
    endgenerate

endmodule

//--- verilog/simt_lane.sv
module simt_lane
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           enable,
    input  logic           issue,
    input  decoded_instr_t decoded,
    input  data_t          op1,
    input  data_t          op2,
    input  logic           dmem_ready,
    output data_t          result,
    output logic           store_busy,
    output logic           dmem_valid,
    output dmem_write_t    dmem_write
);

    data_t store_address;
    logic accept;

    always_comb begin
        case (decoded.op)
            ADD: result = op1 + op2;
            SUB: result = op1 - op2;
            AND: result = op1 & op2;
            OR: result = op1 | op2;
            ADDI: result = op1 + decoded.imm;
            default: result = '0;
        endcase
    end

    assign store_address = op1 + decoded.imm;
    assign accept = issue && enable && !store_busy;

    // Busy for as long as the write request is outstanding
    assign store_busy = dmem_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_valid <= 1'b0;
        end else if (accept) begin
            dmem_valid <= 1'b1;
        end else if (dmem_valid && dmem_ready) begin
            dmem_valid <= 1'b0;
        end
    end

    // Payload is only loaded while idle, so it stays put until the transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            dmem_write.address <= store_address[DMEM_ADDR_WIDTH-1:0];
            dmem_write.data <= op2;
        end
    end

endmodule

//--- verilog/warp_scheduler.sv
module warp_scheduler
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  kernel_config_t              kernel_config,
    input  logic [WARPS_PER_CORE-1:0]   fetch_done,
    input  decoded_instr_t              decoded [WARPS_PER_CORE],
    input  lane_mask_t                  store_busy,
    output warp_state_t                 warp_state [WARPS_PER_CORE],
    output imem_addr_t                  pc [WARPS_PER_CORE],
    output logic [WARP_INDEX_WIDTH-1:0] current_warp,
    output logic                        issue,
    output logic                        done
);

    logic launched;
    logic [WARPS_PER_CORE-1:0] eligible;
    logic [WARPS_PER_CORE-1:0] at_barrier;
    logic [WARPS_PER_CORE-1:0] retired;
    logic barrier_open;
    logic all_done;
    logic [WARP_INDEX_WIDTH-1:0] next_warp;
    warp_state_t current_state;
    decoded_instr_t current_instr;

    assign current_state = warp_state[current_warp];
    assign current_instr = decoded[current_warp];
    assign issue = (current_state == WARP_REQUEST) && (current_instr.op == STORE);

    always_comb begin
        for (int w = 0; w < WARPS_PER_CORE; w++) begin
            eligible[w] = !(warp_state[w] inside {WARP_IDLE, WARP_FETCH, WARP_DONE});
            at_barrier[w] = (warp_state[w] == WARP_SYNC_WAIT);
            // Unlaunched warps stay IDLE and never hold the barrier
            retired[w] = (warp_state[w] inside {WARP_IDLE, WARP_DONE});
        end
    end

    assign barrier_open = (|at_barrier) && ((at_barrier | retired) == '1);
    assign all_done = launched && (&retired);

    // Round robin, walked backwards so the nearest eligible warp wins
    always_comb begin
        int idx;
        next_warp = current_warp;
        for (int k = WARPS_PER_CORE; k >= 1; k--) begin
            idx = (int'(current_warp) + k) % WARPS_PER_CORE;
            if (eligible[idx]) begin
                next_warp = idx[WARP_INDEX_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            launched <= 1'b0;
            done <= 1'b0;
            current_warp <= '0;
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                warp_state[w] <= WARP_IDLE;
                pc[w] <= '0;
            end
        end else if (!launched) begin
            if (start) begin
                launched <= 1'b1;
                for (int w = 0; w < WARPS_PER_CORE; w++) begin
                    if (data_t'(w) < kernel_config.num_warps) begin
                        warp_state[w] <= WARP_FETCH;
                        pc[w] <= kernel_config.base_address;
                    end
                end
            end
        end else begin
            if (all_done) begin
                done <= 1'b1;
            end
            // Fetch completion and barrier release apply to every warp
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                if (warp_state[w] == WARP_FETCH && fetch_done[w]) begin
                    warp_state[w] <= WARP_DECODE;
                end
                if (at_barrier[w] && barrier_open) begin
                    warp_state[w] <= WARP_FETCH;
                end
            end
            // A warp parked at the barrier also hands the lanes over
            if (current_state inside {WARP_UPDATE, WARP_SYNC_WAIT, WARP_DONE}) begin
                current_warp <= next_warp;
            end
            case (current_state)
                WARP_DECODE: warp_state[current_warp] <= WARP_REQUEST;
                WARP_REQUEST: warp_state[current_warp] <= WARP_WAIT;
                WARP_WAIT: begin
                    if (!(|store_busy)) begin
                        warp_state[current_warp] <= WARP_EXECUTE;
                    end
                end
                WARP_EXECUTE: warp_state[current_warp] <= WARP_UPDATE;
                WARP_UPDATE: begin
                    pc[current_warp] <= pc[current_warp] + 1'b1;
                    if (current_instr.op == HALT) begin
                        warp_state[current_warp] <= WARP_DONE;
                    end else if (current_instr.op == SYNC) begin
                        warp_state[current_warp] <= WARP_SYNC_WAIT;
                    end else begin
                        warp_state[current_warp] <= WARP_FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/compute_core.sv
module compute_core
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  kernel_config_t            kernel_config,
    output logic                      done,
    output logic [WARPS_PER_CORE-1:0] imem_valid,
    output imem_addr_t                imem_address [WARPS_PER_CORE],
    input  logic [WARPS_PER_CORE-1:0] imem_ready,
    input  instruction_t              imem_data [WARPS_PER_CORE],
    output lane_mask_t                dmem_valid,
    output dmem_write_t               dmem_write [THREADS_PER_WARP],
    input  lane_mask_t                dmem_ready
);

    warp_state_t warp_state [WARPS_PER_CORE];
    imem_addr_t pc [WARPS_PER_CORE];
    logic [WARPS_PER_CORE-1:0] fetch_done;
    instruction_t instruction [WARPS_PER_CORE];
    decoded_instr_t decoded [WARPS_PER_CORE];
    data_t rs1_data [WARPS_PER_CORE][THREADS_PER_WARP];
    data_t rs2_data [WARPS_PER_CORE][THREADS_PER_WARP];
    data_t lane_result [THREADS_PER_WARP];
    lane_mask_t store_busy;
    logic [WARP_INDEX_WIDTH-1:0] current_warp;
    logic issue;
    decoded_instr_t current_instr;

    assign current_instr = decoded[current_warp];

    generate
        for (genvar w = 0; w < WARPS_PER_CORE; w++) begin : g_warp
            logic reg_write;

            // Write back only in this warp's own EXECUTE cycle
            assign reg_write = (current_warp == WARP_INDEX_WIDTH'(w)) &&
                               (warp_state[w] == WARP_EXECUTE) && decoded[w].reg_write;

            warp_fetcher fetcher_inst (
                .clk(clk),
                .reset(reset),
                .warp_state(warp_state[w]),
                .pc(pc[w]),
                .imem_ready(imem_ready[w]),
                .imem_data(imem_data[w]),
                .imem_valid(imem_valid[w]),
                .imem_address(imem_address[w]),
                .fetch_done(fetch_done[w]),
                .instruction(instruction[w])
            );

            instr_decoder decoder_inst (
                .clk(clk),
                .reset(reset),
                .warp_state(warp_state[w]),
                .instruction(instruction[w]),
                .decoded(decoded[w])
            );

            // No divergence in this ISA, every lane of a warp runs
            vector_reg_file reg_file_inst (
                .clk(clk),
                .reset(reset),
                .warp_id(WARP_INDEX_WIDTH'(w)),
                .write_enable(reg_write),
                .rd(decoded[w].rd),
                .rs1(decoded[w].rs1),
                .rs2(decoded[w].rs2),
                .result(lane_result),
                .lane_mask('1),
                .rs1_data(rs1_data[w]),
                .rs2_data(rs2_data[w])
            );
        end

        // Lanes are shared, operands come from the selected warp
        for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_lane
            simt_lane lane_inst (
                .clk(clk),
                .reset(reset),
                .enable(1'b1),
                .issue(issue),
                .decoded(current_instr),
                .op1(rs1_data[current_warp][l]),
                .op2(rs2_data[current_warp][l]),
                .dmem_ready(dmem_ready[l]),
                .result(lane_result[l]),
                .store_busy(store_busy[l]),
                .dmem_valid(dmem_valid[l]),
                .dmem_write(dmem_write[l])
            );
        end
    endgenerate

    warp_scheduler scheduler_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .kernel_config(kernel_config),
        .fetch_done(fetch_done),
        .decoded(decoded),
        .store_busy(store_busy),
        .warp_state(warp_state),
        .pc(pc),
        .current_warp(current_warp),
        .issue(issue),
        .done(done)
    );

endmodule

//--- tests/compute_core_chk.sv
module compute_core_chk
    import core_cfg_pkg::*;
(
    input logic                      clk,
    input logic                      reset,
    input logic                      done,
    input logic [WARPS_PER_CORE-1:0] imem_valid,
    input imem_addr_t                imem_address [WARPS_PER_CORE],
    input logic [WARPS_PER_CORE-1:0] imem_ready,
    input lane_mask_t                dmem_valid,
    input dmem_write_t               dmem_write [THREADS_PER_WARP],
    input lane_mask_t                dmem_ready
);

    generate
        for (genvar w = 0; w < WARPS_PER_CORE; w++) begin : g_imem
            // Fetch request held with the same address until accepted
            a_imem_hold: assert property (@(posedge clk) disable iff (reset)
                imem_valid[w] && !imem_ready[w] |=>
                    imem_valid[w] && $stable(imem_address[w]))
            else $error("instruction request of warp %0d changed before ready", w);
        end
        for (genvar l = 0; l < THREADS_PER_WARP; l++) begin : g_dmem
            a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
                dmem_valid[l] && !dmem_ready[l] |=>
                    dmem_valid[l] && $stable(dmem_write[l]))
            else $error("store request of lane %0d changed before ready", l);
        end
    endgenerate

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !(|imem_valid) && !(|dmem_valid))
    else $error("valid high while in reset");

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done)
    else $error("done fell without reset");

endmodule

bind compute_core compute_core_chk chk0 (
    .clk(clk),
    .reset(reset),
    .done(done),
    .imem_valid(imem_valid),
    .imem_address(imem_address),
    .imem_ready(imem_ready),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_ready(dmem_ready)
);

//--- tests/compute_core_tb.sv
module compute_core_tb
    import core_cfg_pkg::*;
    import gpu_isa_pkg::*;
();

    localparam int TEST_WORDS = 256;
    localparam int HEADER_WORDS = 6;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;

    logic clk;
    logic reset;
    logic start;
    kernel_config_t kernel_config;
    logic done;
    logic [WARPS_PER_CORE-1:0] imem_valid;
    imem_addr_t imem_address [WARPS_PER_CORE];
    logic [WARPS_PER_CORE-1:0] imem_ready;
    instruction_t imem_data [WARPS_PER_CORE];
    lane_mask_t dmem_valid;
    dmem_write_t dmem_write [THREADS_PER_WARP];
    lane_mask_t dmem_ready;

    logic [31:0] tests [TEST_WORDS];
    instruction_t imem [2**IMEM_ADDR_WIDTH];
    data_t dmem [2**DMEM_ADDR_WIDTH];
    imem_addr_t base_address;
    int num_warps;
    int program_length;
    int pair_count;
    int pre_marker;
    int post_marker;
    logic throttle;
    logic timed_out;
    logic [31:0] rng_state;
    int store_count;
    int pre_seen;
    int error_count;
    int check_count;

    compute_core dut0 (
        .clk(clk),
        .reset(reset),
        .start(start),
        .kernel_config(kernel_config),
        .done(done),
        .imem_valid(imem_valid),
        .imem_address(imem_address),
        .imem_ready(imem_ready),
        .imem_data(imem_data),
        .dmem_valid(dmem_valid),
        .dmem_write(dmem_write),
        .dmem_ready(dmem_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input data_t actual, input data_t expected, input string message);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, message, actual, expected);
        end
    endtask

    task automatic record_store(input dmem_write_t req);
        int addr;
        int threads;
        addr = int'(req.address);
        threads = num_warps * THREADS_PER_WARP;
        dmem[addr] = req.data;
        store_count++;
        if (addr >= pre_marker && addr < pre_marker + threads) begin
            pre_seen++;
        end
        // Every pre-SYNC marker must already be in memory
        if (addr >= post_marker && addr < post_marker + threads) begin
            check_equal(data_t'(pre_seen), data_t'(threads),
                        $sformatf("post-SYNC store to 0x%0h ahead of the barrier", addr));
        end
    endtask

    task automatic load_tests();
        $readmemh("tests/core_tests.dat", tests);
        base_address = tests[0][IMEM_ADDR_WIDTH-1:0];
        num_warps = int'(tests[1]);
        program_length = int'(tests[2]);
        pair_count = int'(tests[3]);
        pre_marker = int'(tests[4]);
        post_marker = int'(tests[5]);
        // Unused words are NOPs carrying their own address
        for (int a = 0; a < 2**IMEM_ADDR_WIDTH; a++) begin
            imem[a] = instruction_t'(a);
        end
        for (int i = 0; i < program_length; i++) begin
            imem[int'(base_address) + i] = tests[HEADER_WORDS + i];
        end
    endtask

    task automatic run_kernel(input logic throttled);
        int limit;
        int cycles;
        int addr;
        int pairs_at;
        limit = program_length * num_warps * 40 + 200;
        cycles = 0;
        pairs_at = HEADER_WORDS + program_length;
        throttle <= throttled;
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_equal(data_t'(done), 0, "done after reset");
        check_equal(data_t'(imem_valid), 0, "instruction valid after reset");
        check_equal(data_t'(dmem_valid), 0, "data valid after reset");
        kernel_config.base_address <= base_address;
        kernel_config.num_warps <= data_t'(num_warps);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles", limit);
            error_count++;
            timed_out = 1'b1;
        end else begin
            $display("Run with throttle=%0b finished after %0d cycles", throttled, cycles);
            check_equal(data_t'(store_count), data_t'(pair_count), "number of data stores");
            for (int i = 0; i < pair_count; i++) begin
                addr = int'(tests[pairs_at + 2 * i]);
                check_equal(dmem[addr], tests[pairs_at + 2 * i + 1],
                            $sformatf("data word at 0x%0h", addr));
            end
            // A second start must not wake the core
            start <= 1'b1;
            for (int i = 0; i < IDLE_CYCLES; i++) begin
                @(posedge clk);
                start <= 1'b0;
                check_equal(data_t'(done), 1, "done held high");
                check_equal(data_t'(imem_valid), 0, "instruction valid after done");
                check_equal(data_t'(dmem_valid), 0, "data valid after done");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Instruction memory and random ready for both ports
    initial begin
        rng_state = 32'd988;
        imem_ready <= '0;
        dmem_ready <= '0;
        for (int w = 0; w < WARPS_PER_CORE; w++) begin
            imem_data[w] <= '0;
        end
        forever begin
            @(posedge clk);
            rng_state = xorshift32(rng_state);
            for (int w = 0; w < WARPS_PER_CORE; w++) begin
                imem_data[w] <= imem[imem_address[w]];
                imem_ready[w] <= !throttle || (rng_state[2 * w +: 2] != 2'b00);
            end
            for (int l = 0; l < THREADS_PER_WARP; l++) begin
                dmem_ready[l] <= !throttle || (rng_state[8 + 2 * l +: 2] != 2'b00);
            end
        end
    end

    // Data memory, one write per completed transfer
    always @(posedge clk) begin
        if (reset) begin
            store_count = 0;
            pre_seen = 0;
            for (int a = 0; a < 2**DMEM_ADDR_WIDTH; a++) begin
                dmem[a] = 32'hBAD0_0000 | data_t'(a);
            end
        end else begin
            for (int l = 0; l < THREADS_PER_WARP; l++) begin
                if (dmem_valid[l] && dmem_ready[l]) begin
                    record_store(dmem_write[l]);
                end
            end
        end
    end

    initial begin
        reset <= 1'b1;
        start <= 1'b0;
        kernel_config <= '0;
        throttle = 1'b0;
        timed_out = 1'b0;
        error_count = 0;
        check_count = 0;
        load_tests();
        run_kernel(1'b0);
        if (!timed_out) begin
            run_kernel(1'b1);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tests/core_tests.dat
// Header: base address, warp count, program length, pair count, pre/post marker base
// Then the program words, then expected data memory as address/value pairs
20 2 11 38 50 60
52000064 53100007 14230000 25230000 36430000 47430000
60110000 60140010 60150020 60160030 60170040 5800FFFE
60180050 70000000 59300100 60190060 80000000
00 0 01 1 02 2 03 3 04 4 05 5 06 6 07 7
10 6B 11 6C 12 6D 13 6E 14 6F 15 70 16 71 17 72
20 5D 21 5C 22 5B 23 5A 24 59 25 58 26 57 27 56
30 3 31 8 32 9 33 A 34 B 35 0 36 1 37 2
40 6F 41 6C 42 6D 43 6E 44 6F 45 7C 46 7D 47 7E
50 FFFFFFFE 51 FFFFFFFE 52 FFFFFFFE 53 FFFFFFFE
54 FFFFFFFE 55 FFFFFFFE 56 FFFFFFFE 57 FFFFFFFE
60 107 61 108 62 109 63 10A 64 10B 65 10C 66 10D 67 10E

//--- compile.f
verilog/core_cfg_pkg.sv
verilog/gpu_isa_pkg.sv
verilog/warp_fetcher.sv
verilog/instr_decoder.sv
verilog/vector_reg_file.sv
verilog/simt_lane.sv
verilog/warp_scheduler.sv
verilog/compute_core.sv
tests/compute_core_chk.sv
tests/compute_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= compute_core_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= -Wall
FAIL_MSG ?= Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
